//--- filelist.f
src/rsa_pkg.sv
src/tb_read_stage.sv
src/tb_douta_map.sv
src/rsa_dot_stage.sv
src/rsa_feed_top.sv
tb/tb_clkgen.sv
tb/rsa_feed_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench; exit status is the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
  --top-module rsa_feed_tb \
  -f filelist.f

./obj_dir/Vrsa_feed_tb

//--- tb/rsa_feed_tb.sv
module rsa_feed_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rsa_pkg::*;

  localparam int CLK_NS = 40;
  // directed commands and then the random mix
  localparam int N_DIRECTED = 9;
  localparam int N_RAND = 200;
  localparam int N_CMD = N_DIRECTED + N_RAND;
  // command edge to result_valid
  localparam int RES_LAT = MAP_LAT + 1;
  // every command slot, the buffer fill, and slack for reset and drain
  localparam int WATCHDOG_NS = (N_CMD * CMD_GAP + TB_DEPTH + 50) * CLK_NS;

  logic                        clk;
  logic                        sys_rst;
  logic                        wr_en;
  logic [TB_AW-1:0]            wr_addr;
  logic [BUS_DW-1:0]           wr_data;
  logic                        cmd_valid;
  logic [TB_AW-1:0]            cmd_addr;
  logic [TB_DOUTA_SEL_DW-1:0]  cmd_sel;
  logic                        l_k_0;
  logic signed [ACC_DW-1:0]    result;
  logic                        result_valid;

  // buffer and bank models
  logic [BUS_DW-1:0]           buf_model [TB_DEPTH];
  logic signed [RSA_DW-1:0]    a_model [X];
  logic signed [RSA_DW-1:0]    m_model [X];

  // expected results and the edge 0 of their commands in issue order
  logic signed [ACC_DW-1:0]    exp_q [$];
  int                          edge_q [$];
  int                          cyc = 0;
  int                          n_expected = 0;
  int                          n_checked = 0;
  logic [31:0]                 rng;

  tb_clkgen #(
    .PERIOD_NS  (CLK_NS),
    .RST_CYCLES (2)
  ) u_clkgen (
    .clk     (clk),
    .sys_rst (sys_rst)
  );

  rsa_feed_top dut (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .cmd_valid    (cmd_valid),
    .cmd_addr     (cmd_addr),
    .cmd_sel      (cmd_sel),
    .l_k_0        (l_k_0),
    .result       (result),
    .result_valid (result_valid)
  );

  // rising edge count
  // edge 0 of a command is cyc + 1 at its drive time
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // applies one command to the model banks and returns the new dot product
  function automatic logic signed [ACC_DW-1:0] ref_dot(
    input logic              dst,
    input logic [DIR_DW-1:0] dir,
    input logic              lk0,
    input logic [BUS_DW-1:0] word
  );
    logic signed [RSA_DW-1:0] w [L];
    logic signed [RSA_DW-1:0] bank [X];
    logic signed [ACC_DW-1:0] pa;
    logic signed [ACC_DW-1:0] pm;
    logic signed [ACC_DW-1:0] acc;
    for (int i = 0; i < L; i++) begin
      w[i] = word[i*RSA_DW +: RSA_DW];
    end
    case (dir)
      DIR_IDLE: begin
        for (int j = 0; j < X; j++) begin
          bank[j] = '0;
        end
      end
      DIR_POS: begin
        for (int j = 0; j < X; j++) begin
          bank[j] = w[j];
        end
      end
      DIR_NEG: begin
        for (int j = 0; j < X; j++) begin
          bank[j] = w[L-1-j];
        end
      end
      default: begin
        // new vector takes one word half into lanes 0 and 1 and clears the upper lanes
        bank[0] = lk0 ? w[0] : w[2];
        bank[1] = lk0 ? w[1] : w[3];
        bank[2] = '0;
        bank[3] = '0;
      end
    endcase
    for (int j = 0; j < X; j++) begin
      if (dst == TBA_M) begin
        m_model[j] = bank[j];
      end else begin
        a_model[j] = bank[j];
      end
    end
    acc = '0;
    for (int j = 0; j < X; j++) begin
      pa = a_model[j];
      pm = m_model[j];
      acc = acc + pa * pm;
    end
    return acc;
  endfunction

  // one random word per address written back to back
  task automatic fill_buffer();
    logic [BUS_DW-1:0] word;
    for (int a = 0; a < TB_DEPTH; a++) begin
      @(negedge clk);
      word = {next_rand(), next_rand()};
      wr_en = 1'b1;
      wr_addr = TB_AW'(a);
      wr_data = word;
      buf_model[a] = word;
    end
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  // single cycle strobe that returns once the next command keeps the gap
  task automatic issue_cmd(
    input logic              dst,
    input logic [DIR_DW-1:0] dir,
    input logic              lk0,
    input logic [TB_AW-1:0]  addr
  );
    logic signed [ACC_DW-1:0] exp_val;
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_addr = addr;
    cmd_sel = {dst, dir};
    l_k_0 = lk0;
    exp_val = ref_dot(dst, dir, lk0, buf_model[addr]);
    // only M commands produce a result
    if (dst == TBA_M) begin
      exp_q.push_back(exp_val);
      edge_q.push_back(cyc + 1);
      n_expected++;
    end
    @(negedge clk);
    cmd_valid = 1'b0;
    repeat (CMD_GAP - 2) @(negedge clk);
  endtask

  initial begin : stimulus
    logic [31:0]       r;
    logic              dst;
    logic [DIR_DW-1:0] dir;
    logic              lk0;
    logic [TB_AW-1:0]  addr;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    cmd_valid = 1'b0;
    cmd_addr = '0;
    cmd_sel = '0;
    l_k_0 = 1'b0;
    rng = 32'hcc7d;
    for (int j = 0; j < X; j++) begin
      a_model[j] = '0;
      m_model[j] = '0;
    end
    @(negedge clk);
    while (sys_rst !== 1'b0) @(negedge clk);
    fill_buffer();

    // M against the reset A bank
    issue_cmd(TBA_M, DIR_POS, 1'b0, 4'd0);
    // plain lane-wise dot product
    issue_cmd(TBA_A, DIR_POS, 1'b0, 4'd1);
    issue_cmd(TBA_M, DIR_POS, 1'b0, 4'd2);
    // reversed M lanes
    issue_cmd(TBA_A, DIR_POS, 1'b0, 4'd3);
    issue_cmd(TBA_M, DIR_NEG, 1'b0, 4'd4);
    // new vector halves and then an idle clear
    issue_cmd(TBA_A, DIR_POS, 1'b0, 4'd5);
    issue_cmd(TBA_M, DIR_NEW, 1'b1, 4'd6);
    issue_cmd(TBA_M, DIR_NEW, 1'b0, 4'd7);
    issue_cmd(TBA_M, DIR_IDLE, 1'b0, 4'd8);

    // random mix at the minimum gap
    for (int n = 0; n < N_RAND; n++) begin
      r = next_rand();
      dst = r[0];
      dir = r[2:1];
      lk0 = r[3];
      addr = r[4 +: TB_AW];
      issue_cmd(dst, dir, lk0, addr);
    end

    // last result is due within RES_LAT
    // a few quiet cycles after it catch a stray strobe
    repeat (RES_LAT + 2) @(negedge clk);
    if (n_checked == n_expected) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("%0d results checked, %0d M commands issued", n_checked, n_expected);
      $display("Test failed");
      $fatal(1);
    end
  end

  // outputs sampled on the falling edge
  initial begin : compare
    logic signed [ACC_DW-1:0] exp_val;
    int                       issued;
    forever begin
      @(negedge clk);
      if (result_valid === 1'b1) begin
        assert (exp_q.size() != 0) else begin
          $display("result_valid went high with no M command outstanding");
          $display("Test failed");
          $fatal(1);
        end
        exp_val = exp_q.pop_front();
        issued = edge_q.pop_front();
        assert (cyc - issued == RES_LAT) else begin
          $display("result_valid came %0d cycles after its M command instead of %0d",
                   cyc - issued, RES_LAT);
          $display("Test failed");
          $fatal(1);
        end
        assert (result === exp_val) else begin
          $display("[ERROR] %0t result %0d expected %0d", $time, result, exp_val);
          $display("Test failed");
          $fatal(1);
        end
        n_checked++;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test failed");
    $fatal(1);
  end

endmodule

//--- tb/tb_clkgen.sv
module tb_clkgen #(
  parameter int PERIOD_NS = 40,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic sys_rst
);
  timeunit 1ns;
  timeprecision 1ps;

  // free running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // reset seen high by the first RST_CYCLES rising edges
  initial begin
    sys_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    sys_rst = 1'b0;
  end

endmodule

//--- src/rsa_feed_top.sv
module rsa_feed_top (
  input  logic                                  clk,
  input  logic                                  sys_rst,
  input  logic                                  wr_en,
  input  logic [rsa_pkg::TB_AW-1:0]             wr_addr,
  input  logic [rsa_pkg::BUS_DW-1:0]            wr_data,
  input  logic                                  cmd_valid,
  input  logic [rsa_pkg::TB_AW-1:0]             cmd_addr,
  input  logic [rsa_pkg::TB_DOUTA_SEL_DW-1:0]   cmd_sel,
  input  logic                                  l_k_0,
  output logic signed [rsa_pkg::ACC_DW-1:0]     result,
  output logic                                  result_valid
);
  import rsa_pkg::*;

  // read stage to map, one command copy per lane
  logic [BUS_DW-1:0]            tb_douta;
  logic [L-1:0]                 lane_vld;
  logic [L-1:0]                 lane_dst;
  logic [L-1:0][DIR_DW-1:0]     lane_dir;
  logic [L-1:0]                 lane_lk0;

  // map to dot stage
  logic [BANK_DW-1:0]           A_TB_douta;
  logic [BANK_DW-1:0]           M_TB_douta;
  logic                         m_done;

  // skewed buffer read
  tb_read_stage u_read (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .cmd_valid (cmd_valid),
    .cmd_addr  (cmd_addr),
    .cmd_sel   (cmd_sel),
    .l_k_0     (l_k_0),
    .tb_douta  (tb_douta),
    .lane_vld  (lane_vld),
    .lane_dst  (lane_dst),
    .lane_dir  (lane_dir),
    .lane_lk0  (lane_lk0)
  );

  // lanes into A or M bank
  tb_douta_map u_map (
    .clk        (clk),
    .sys_rst    (sys_rst),
    .tb_douta   (tb_douta),
    .lane_vld   (lane_vld),
    .lane_dst   (lane_dst),
    .lane_dir   (lane_dir),
    .lane_lk0   (lane_lk0),
    .A_TB_douta (A_TB_douta),
    .M_TB_douta (M_TB_douta),
    .m_done     (m_done)
  );

  // dot product on each completed M vector
  rsa_dot_stage u_dot (
    .clk          (clk),
    .sys_rst      (sys_rst),
    .A_TB_douta   (A_TB_douta),
    .M_TB_douta   (M_TB_douta),
    .m_done       (m_done),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

//--- src/rsa_dot_stage.sv
module rsa_dot_stage (
  input  logic                                  clk,
  input  logic                                  sys_rst,
  input  logic [rsa_pkg::BANK_DW-1:0]           A_TB_douta,
  input  logic [rsa_pkg::BANK_DW-1:0]           M_TB_douta,
  input  logic                                  m_done,
  output logic signed [rsa_pkg::ACC_DW-1:0]     result,
  output logic                                  result_valid
);
  import rsa_pkg::*;

  // signed views of the bank lanes
  logic signed [RSA_DW-1:0]  a_lane [X];
  logic signed [RSA_DW-1:0]  m_lane [X];
  // one product per lane
  logic signed [PROD_DW-1:0] prod [X];
  logic signed [ACC_DW-1:0]  dot_sum;

  for (genvar j = 0; j < X; j++) begin : g_lane
    assign a_lane[j] = A_TB_douta[j*RSA_DW +: RSA_DW];
    assign m_lane[j] = M_TB_douta[j*RSA_DW +: RSA_DW];
    // full width product, no overflow
    assign prod[j] = a_lane[j] * m_lane[j];
  end

  // adder chain, products sign extended into the accumulator width
  always_comb begin
    dot_sum = '0;
    for (int j = 0; j < X; j++) begin
      dot_sum = dot_sum + prod[j];
    end
  end

  // strobe follows m_done by one cycle
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= m_done;
    end
  end

  // result holds until the next M vector completes
  always_ff @(posedge clk) begin
    if (m_done) begin
      result <= dot_sum;
    end
  end

  // command gap upstream keeps results at least a cycle apart
  a_single_pulse: assert property (@(posedge clk) disable iff (sys_rst)
    result_valid |=> !result_valid);

endmodule

//--- src/tb_douta_map.sv
module tb_douta_map (
  input  logic                                              clk,
  input  logic                                              sys_rst,
  input  logic [rsa_pkg::BUS_DW-1:0]                        tb_douta,
  input  logic [rsa_pkg::L-1:0]                             lane_vld,
  input  logic [rsa_pkg::L-1:0]                             lane_dst,
  input  logic [rsa_pkg::L-1:0][rsa_pkg::DIR_DW-1:0]        lane_dir,
  input  logic [rsa_pkg::L-1:0]                             lane_lk0,
  output logic [rsa_pkg::BANK_DW-1:0]                       A_TB_douta,
  output logic [rsa_pkg::BANK_DW-1:0]                       M_TB_douta,
  output logic                                              m_done
);
  import rsa_pkg::*;

  // operand banks
  logic [RSA_DW-1:0] a_q [X];
  logic [RSA_DW-1:0] m_q [X];

  // per input lane decode
  // put copies the lane into a bank slot, clr zeroes a slot
  logic [L-1:0]       put_en;
  logic [L-1:0]       clr_en;
  logic [LANE_AW-1:0] put_idx [L];
  logic [LANE_AW-1:0] clr_idx [L];

  always_comb begin
    for (int i = 0; i < L; i++) begin
      put_en[i]  = 1'b0;
      clr_en[i]  = 1'b0;
      put_idx[i] = LANE_AW'(i);
      clr_idx[i] = LANE_AW'(i);
      if (lane_vld[i]) begin
        // direction comes from this lane's own command copy
        case (lane_dir[i])
          DIR_IDLE: begin
            clr_en[i] = 1'b1;
          end
          DIR_POS: begin
            put_en[i] = 1'b1;
          end
          DIR_NEG: begin
            // reversed lane order
            put_en[i]  = 1'b1;
            put_idx[i] = LANE_AW'(L - 1 - i);
          end
          DIR_NEW: begin
            if (lane_lk0[i] && i < NEW_HALF) begin
              // low half stays in place, upper slot cleared
              put_en[i]  = 1'b1;
              clr_en[i]  = 1'b1;
              clr_idx[i] = LANE_AW'(i + NEW_HALF);
            end else if (!lane_lk0[i] && i >= NEW_HALF) begin
              // high half moves down, its own slot cleared
              put_en[i]  = 1'b1;
              put_idx[i] = LANE_AW'(i - NEW_HALF);
              clr_en[i]  = 1'b1;
            end
            // other lanes carry no mapped data
          end
        endcase
      end
    end
  end

  // bank update, destination bit picks A or M per lane
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      for (int j = 0; j < X; j++) begin
        a_q[j] <= '0;
        m_q[j] <= '0;
      end
    end else begin
      for (int i = 0; i < L; i++) begin
        if (put_en[i]) begin
          case (lane_dst[i])
            TBA_A: a_q[put_idx[i]] <= tb_douta[i*RSA_DW +: RSA_DW];
            TBA_M: m_q[put_idx[i]] <= tb_douta[i*RSA_DW +: RSA_DW];
          endcase
        end
        if (clr_en[i]) begin
          case (lane_dst[i])
            TBA_A: a_q[clr_idx[i]] <= '0;
            TBA_M: m_q[clr_idx[i]] <= '0;
          endcase
        end
      end
    end
  end

  // last lane of an M command just landed
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      m_done <= 1'b0;
    end else begin
      m_done <= lane_vld[L-1] && (lane_dst[L-1] == TBA_M);
    end
  end

  // flatten banks onto the output buses
  for (genvar j = 0; j < X; j++) begin : g_bank_out
    assign A_TB_douta[j*RSA_DW +: RSA_DW] = a_q[j];
    assign M_TB_douta[j*RSA_DW +: RSA_DW] = m_q[j];
  end

  // lane valids come out of reset in the read stage
  a_vld_known: assert property (@(posedge clk) disable iff (sys_rst)
    !$isunknown(lane_vld));

endmodule

//--- src/tb_read_stage.sv
module tb_read_stage (
  input  logic                                              clk,
  input  logic                                              sys_rst,
  input  logic                                              wr_en,
  input  logic [rsa_pkg::TB_AW-1:0]                         wr_addr,
  input  logic [rsa_pkg::BUS_DW-1:0]                        wr_data,
  input  logic                                              cmd_valid,
  input  logic [rsa_pkg::TB_AW-1:0]                         cmd_addr,
  input  logic [rsa_pkg::TB_DOUTA_SEL_DW-1:0]               cmd_sel,
  input  logic                                              l_k_0,
  output logic [rsa_pkg::BUS_DW-1:0]                        tb_douta,
  output logic [rsa_pkg::L-1:0]                             lane_vld,
  output logic [rsa_pkg::L-1:0]                             lane_dst,
  output logic [rsa_pkg::L-1:0][rsa_pkg::DIR_DW-1:0]        lane_dir,
  output logic [rsa_pkg::L-1:0]                             lane_lk0
);
  import rsa_pkg::*;

  // buffer storage
  logic [BUS_DW-1:0] mem [TB_DEPTH];

  // command shift line, stage k seen by lane k
  logic [L-1:1]                dly_vld;
  logic [TB_AW-1:0]            dly_addr [1:L-1];
  logic [TB_DOUTA_SEL_DW-1:0]  dly_sel [1:L-1];
  logic [L-1:1]                dly_lk0;

  // taps, lane 0 takes the live command
  logic [L-1:0]                tap_vld;
  logic [TB_AW-1:0]            tap_addr [L];
  logic [TB_DOUTA_SEL_DW-1:0]  tap_sel [L];
  logic [L-1:0]                tap_lk0;

  // read registers, lane k loaded at edge k
  logic [L-1:0]                rd_vld;
  logic [RSA_DW-1:0]           rd_data [L];
  logic [TB_DOUTA_SEL_DW-1:0]  rd_sel [L];
  logic [L-1:0]                rd_lk0;

  // synchronous write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    tap_vld[0]  = cmd_valid;
    tap_addr[0] = cmd_addr;
    tap_sel[0]  = cmd_sel;
    tap_lk0[0]  = l_k_0;
    for (int k = 1; k < L; k++) begin
      tap_vld[k]  = dly_vld[k];
      tap_addr[k] = dly_addr[k];
      tap_sel[k]  = dly_sel[k];
      tap_lk0[k]  = dly_lk0[k];
    end
  end

  // valids of the shift line and both register ranks
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      dly_vld  <= '0;
      rd_vld   <= '0;
      lane_vld <= '0;
    end else begin
      for (int k = 1; k < L; k++) begin
        dly_vld[k] <= tap_vld[k-1];
      end
      rd_vld   <= tap_vld;
      lane_vld <= rd_vld;
    end
  end

  // payload follows the valids, each lane keeps its own command copy
  always_ff @(posedge clk) begin
    for (int k = 1; k < L; k++) begin
      dly_addr[k] <= tap_addr[k-1];
      dly_sel[k]  <= tap_sel[k-1];
      dly_lk0[k]  <= tap_lk0[k-1];
    end
    for (int k = 0; k < L; k++) begin
      // lane k slice of the word at its own delayed address
      rd_data[k] <= mem[tap_addr[k]][k*RSA_DW +: RSA_DW];
      rd_sel[k]  <= tap_sel[k];
      rd_lk0[k]  <= tap_lk0[k];
      tb_douta[k*RSA_DW +: RSA_DW] <= rd_data[k];
      lane_dst[k] <= rd_sel[k][SEL_DST_BIT];
      lane_dir[k] <= rd_sel[k][DIR_DW-1:0];
      lane_lk0[k] <= rd_lk0[k];
    end
  end

  // skewed lanes of two commands must never overlap
  a_cmd_gap: assert property (@(posedge clk) disable iff (sys_rst)
    cmd_valid |=> !cmd_valid [*CMD_GAP-1]);

endmodule

//--- src/rsa_pkg.sv
package rsa_pkg;

  // lanes per operand bank, same as buffer lanes in this design
  localparam int X = 4;
  // lanes per transpose buffer word
  localparam int L = 4;

  // one signed lane
  localparam int RSA_DW = 16;
  // one lane product
  localparam int PROD_DW = 2 * RSA_DW;
  // dot product, two guard bits for the sum over four lanes
  localparam int ACC_DW = 2 * RSA_DW + 2;

  // flattened buffer word and operand bank
  localparam int BUS_DW = L * RSA_DW;
  localparam int BANK_DW = X * RSA_DW;
  // index of one output lane
  localparam int LANE_AW = $clog2(X);
  // DIR_NEW moves one half of the word into the low half of the bank
  localparam int NEW_HALF = L / 2;

  // transpose buffer geometry
  localparam int TB_DEPTH = 16;
  localparam int TB_AW = $clog2(TB_DEPTH);

  // select word, bit 2 destination, bits 1:0 direction
  localparam int TB_DOUTA_SEL_DW = 3;
  localparam int SEL_DST_BIT = 2;
  localparam int DIR_DW = 2;

  // destination codes
  localparam logic TBA_A = 1'b0;
  localparam logic TBA_M = 1'b1;

  // direction codes
  localparam logic [DIR_DW-1:0] DIR_IDLE = 2'b00;
  localparam logic [DIR_DW-1:0] DIR_POS = 2'b01;
  localparam logic [DIR_DW-1:0] DIR_NEG = 2'b10;
  localparam logic [DIR_DW-1:0] DIR_NEW = 2'b11;

  // command spacing, keeps skewed lanes of two commands apart
  localparam int CMD_GAP = 4;
  // command edge to last lane in the banks
  localparam int MAP_LAT = L + 1;

endpackage
